/* design/lq_pkg.sv */
// load queue shared types
// sizes, op encoding and the packets passed between stages
package lq_pkg;

    localparam int LQ_CREDITS = 4;
    localparam int MISS_DEPTH = 4;
    localparam int ROB_W      = 6;
    localparam int REG_W      = 6;
    localparam int TAG_W      = 19;
    localparam int IDX_W      = 10;
    localparam int IB_PTR_W   = $clog2(LQ_CREDITS);
    localparam int MQ_PTR_W   = $clog2(MISS_DEPTH);

    // op size field
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    // top bit set selects zero extension
    typedef struct packed {
        logic       zext;
        logic [1:0] size;
    } lq_op_t;

    typedef struct packed {
        logic             io;
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] index;
        logic [1:0]       offset;
    } lq_addr_fields_t;

    // same word, seen raw or split for the cache
    typedef union packed {
        logic [31:0]     raw;
        lq_addr_fields_t f;
    } lq_addr_u;

    typedef struct packed {
        logic [ROB_W-1:0] rob;
        lq_op_t           op;
        lq_addr_u         addr;
        logic [REG_W-1:0] dest;
    } lq_load_t;

    // store buffer conflict report
    typedef struct packed {
        logic        valid;
        logic        resolvable;
        logic [31:0] data;
        logic [3:0]  mask;
    } lq_fwd_t;

    typedef struct packed {
        lq_load_t ld;
        lq_fwd_t  fwd;
    } lq_req_t;

    // parked loads keep no forward data
    typedef lq_load_t lq_miss_t;

    typedef struct packed {
        logic             en;
        logic [ROB_W-1:0] rob;
        logic [REG_W-1:0] dest;
        logic [31:0]      data;
    } lq_wb_t;

endpackage

/* design/lq_issue_buffer.sv */
// load queue issue buffer
`timescale 1ns/1ps

module lq_issue_buffer
    import lq_pkg::*;
(
    input  logic    cpu_clock_i,
    input  logic    arst_n_i,
    input  logic    flush_i,
    input  logic    lsu_vld_i,
    input  lq_req_t lsu_req_i,
    input  logic    take_i,
    output logic    head_vld_o,
    output lq_req_t head_o,
    output logic    lsu_credit_o
);

    lq_req_t             entries [LQ_CREDITS];
    logic [IB_PTR_W:0]   wr_ptr;
    logic [IB_PTR_W:0]   rd_ptr;
    logic                empty;
    logic                full;
    logic                push;
    logic                pop;

    // extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[IB_PTR_W] != rd_ptr[IB_PTR_W]) &&
                   (wr_ptr[IB_PTR_W-1:0] == rd_ptr[IB_PTR_W-1:0]);

    assign push = lsu_vld_i && !full;
    assign pop  = take_i && !empty;

    assign head_vld_o = !empty;
    assign head_o     = entries[rd_ptr[IB_PTR_W-1:0]];

    // every entry leaving hands a credit back to the LSU
    assign lsu_credit_o = pop;

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (push) begin
            entries[wr_ptr[IB_PTR_W-1:0]] <= lsu_req_i;
        end
    end

endmodule

/* design/lq_lookup_stage.sv */
// load queue lookup stage
`timescale 1ns/1ps

module lq_lookup_stage
    import lq_pkg::*;
(
    input  logic             cpu_clock_i,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic             head_vld_i,
    input  lq_req_t          head_i,
    output logic             take_o,
    input  logic             mem_ack_i,
    input  logic             miss_full_i,
    output logic [TAG_W-1:0] cache_tag_o,
    input  logic             tag_hit_i,
    input  logic             tag_way_i,
    output logic [IDX_W:0]   ram_addr_o,
    output logic             miss_push_o,
    output lq_miss_t         miss_o,
    output logic             hit_vld_o,
    output lq_req_t          hit_o
);

    logic           lookup_stall;
    logic           park;
    logic           fwd_ok;
    logic [IDX_W:0] ram_addr_q;
    logic           hit_vld_q;
    lq_req_t        hit_q;
    lq_req_t        hit_d;

    // a memory response owns the writeback port this cycle
    assign lookup_stall = mem_ack_i;

    assign take_o = head_vld_i && !lookup_stall && !miss_full_i && !flush_i;

    assign cache_tag_o = head_i.ld.addr.f.tag;

    // io, tag miss or a conflict the store buffer can't forward
    assign fwd_ok = head_i.fwd.valid && head_i.fwd.resolvable;
    assign park   = head_i.ld.addr.f.io || !tag_hit_i ||
                    (head_i.fwd.valid && !head_i.fwd.resolvable);

    assign miss_push_o = take_o && park;
    assign miss_o      = head_i.ld;

    always_comb begin
        hit_d = head_i;
        if (!fwd_ok) begin
            hit_d.fwd.mask = 4'b0000;
        end
    end

    // during a stall the held hit re-reads its word so the data
    // lines up again in the following cycle
    assign ram_addr_o = lookup_stall ? ram_addr_q
                                     : {tag_way_i, head_i.ld.addr.f.index};

    assign hit_vld_o = hit_vld_q && !lookup_stall;
    assign hit_o     = hit_q;

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_vld_q <= 1'b0;
        end else if (flush_i) begin
            hit_vld_q <= 1'b0;
        end else if (!lookup_stall) begin
            hit_vld_q <= take_o && !park;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (take_o) begin
            hit_q      <= hit_d;
            ram_addr_q <= {tag_way_i, head_i.ld.addr.f.index};
        end
    end

endmodule

/* design/lq_miss_queue.sv */
// missed load queue
// parks loads until they are oldest and stores have drained
`timescale 1ns/1ps

module lq_miss_queue
    import lq_pkg::*;
(
    input  logic             cpu_clock_i,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic             push_i,
    input  lq_miss_t         push_data_i,
    output logic             full_o,
    input  logic [ROB_W-2:0] oldest_rob_i,
    input  logic             store_buf_empty_i,
    output logic             mem_req_o,
    output logic [31:0]      mem_addr_o,
    input  logic             mem_ack_i,
    input  logic [31:0]      mem_data_i,
    output logic             resp_vld_o,
    output lq_miss_t         resp_o,
    output logic [31:0]      resp_data_o
);

    lq_miss_t          entries [MISS_DEPTH];
    logic [MQ_PTR_W:0] wr_ptr;
    logic [MQ_PTR_W:0] rd_ptr;
    logic              empty;
    logic              push;
    logic              pop;
    logic              issue;
    lq_miss_t          head;

    assign empty  = (wr_ptr == rd_ptr);
    assign full_o = (wr_ptr[MQ_PTR_W] != rd_ptr[MQ_PTR_W]) &&
                    (wr_ptr[MQ_PTR_W-1:0] == rd_ptr[MQ_PTR_W-1:0]);

    assign head = entries[rd_ptr[MQ_PTR_W-1:0]];
    assign push = push_i && !full_o;

    // only the head may go out, one request at a time
    assign issue = !empty && !mem_req_o && store_buf_empty_i &&
                   (head.rob[ROB_W-2:0] == oldest_rob_i);

    // the response retires the head straight to writeback
    assign resp_vld_o  = mem_req_o && mem_ack_i;
    assign resp_o      = head;
    assign resp_data_o = mem_data_i;
    assign pop         = resp_vld_o;

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_req_o <= 1'b0;
        end else if (flush_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_req_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (issue) begin
                mem_req_o <= 1'b1;
            end else if (mem_ack_i) begin
                mem_req_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (push) begin
            entries[wr_ptr[MQ_PTR_W-1:0]] <= push_data_i;
        end
        // address held steady while the request is up
        if (issue) begin
            mem_addr_o <= head.addr.raw;
        end
    end

endmodule

/* design/lq_writeback_stage.sv */
// load queue writeback stage
`timescale 1ns/1ps

module lq_writeback_stage
    import lq_pkg::*;
(
    input  logic        cpu_clock_i,
    input  logic        arst_n_i,
    input  logic        flush_i,
    input  logic        hit_vld_i,
    input  lq_req_t     hit_i,
    input  logic [31:0] ram_data_i,
    input  logic        resp_vld_i,
    input  lq_miss_t    resp_i,
    input  logic [31:0] resp_data_i,
    output lq_wb_t      wb_o
);

    logic [31:0]      merged;
    logic [31:0]      raw_word;
    lq_load_t         ld;
    logic [31:0]      result;
    logic             wb_en_q;
    logic [ROB_W-1:0] wb_rob_q;
    logic [REG_W-1:0] wb_dest_q;
    logic [31:0]      wb_data_q;

    // pick the lane and extend to a full register
    function automatic logic [31:0] format_load(logic [31:0] word, lq_op_t op,
                                                logic [1:0] offset);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] r;
        b = word[{offset, 3'b000} +: 8];
        h = offset[1] ? word[31:16] : word[15:0];
        case (op.size)
            SZ_BYTE: r = op.zext ? {24'h000000, b} : {{24{b[7]}}, b};
            SZ_HALF: r = op.zext ? {16'h0000, h} : {{16{h[15]}}, h};
            SZ_WORD: r = word;
            default: r = word;
        endcase
        return r;
    endfunction

    // forwarded store bytes win over the RAM word
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[i*8 +: 8] = hit_i.fwd.mask[i] ? hit_i.fwd.data[i*8 +: 8]
                                                 : ram_data_i[i*8 +: 8];
        end
    end

    // lookup stalls on a response, so at most one source is valid
    assign ld       = resp_vld_i ? resp_i : hit_i.ld;
    assign raw_word = resp_vld_i ? resp_data_i : merged;
    assign result   = format_load(raw_word, ld.op, ld.addr.f.offset);

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_en_q <= 1'b0;
        end else if (flush_i) begin
            wb_en_q <= 1'b0;
        end else begin
            // x0 is never written
            wb_en_q <= (hit_vld_i || resp_vld_i) && (ld.dest != '0);
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        wb_rob_q  <= ld.rob;
        wb_dest_q <= ld.dest;
        wb_data_q <= result;
    end

    assign wb_o.en   = wb_en_q;
    assign wb_o.rob  = wb_rob_q;
    assign wb_o.dest = wb_dest_q;
    assign wb_o.data = wb_data_q;

endmodule

/* design/load_queue_top.sv */
// load queue top
`timescale 1ns/1ps

module load_queue_top
    import lq_pkg::*;
(
    input  logic             cpu_clock_i,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic             lsu_vld_i,
    input  lq_req_t          lsu_req_i,
    output logic             lsu_credit_o,
    output logic [TAG_W-1:0] cache_tag_o,
    input  logic             tag_hit_i,
    input  logic             tag_way_i,
    output logic [IDX_W:0]   ram_addr_o,
    input  logic [31:0]      ram_data_i,
    input  logic [ROB_W-2:0] oldest_rob_i,
    input  logic             store_buf_empty_i,
    output logic             mem_req_o,
    output logic [31:0]      mem_addr_o,
    input  logic             mem_ack_i,
    input  logic [31:0]      mem_data_i,
    output lq_wb_t           wb_o
);

    logic        head_vld;
    lq_req_t     head;
    logic        take;
    logic        miss_push;
    lq_miss_t    miss;
    logic        miss_full;
    logic        hit_vld;
    lq_req_t     hit;
    logic        resp_vld;
    lq_miss_t    resp;
    logic [31:0] resp_data;

    lq_issue_buffer u_issue_buffer (
        .cpu_clock_i  (cpu_clock_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .lsu_vld_i    (lsu_vld_i),
        .lsu_req_i    (lsu_req_i),
        .take_i       (take),
        .head_vld_o   (head_vld),
        .head_o       (head),
        .lsu_credit_o (lsu_credit_o)
    );

    lq_lookup_stage u_lookup (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .head_vld_i  (head_vld),
        .head_i      (head),
        .take_o      (take),
        .mem_ack_i   (mem_ack_i),
        .miss_full_i (miss_full),
        .cache_tag_o (cache_tag_o),
        .tag_hit_i   (tag_hit_i),
        .tag_way_i   (tag_way_i),
        .ram_addr_o  (ram_addr_o),
        .miss_push_o (miss_push),
        .miss_o      (miss),
        .hit_vld_o   (hit_vld),
        .hit_o       (hit)
    );

    lq_miss_queue u_miss_queue (
        .cpu_clock_i       (cpu_clock_i),
        .arst_n_i          (arst_n_i),
        .flush_i           (flush_i),
        .push_i            (miss_push),
        .push_data_i       (miss),
        .full_o            (miss_full),
        .oldest_rob_i      (oldest_rob_i),
        .store_buf_empty_i (store_buf_empty_i),
        .mem_req_o         (mem_req_o),
        .mem_addr_o        (mem_addr_o),
        .mem_ack_i         (mem_ack_i),
        .mem_data_i        (mem_data_i),
        .resp_vld_o        (resp_vld),
        .resp_o            (resp),
        .resp_data_o       (resp_data)
    );

    lq_writeback_stage u_writeback (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .hit_vld_i   (hit_vld),
        .hit_i       (hit),
        .ram_data_i  (ram_data_i),
        .resp_vld_i  (resp_vld),
        .resp_i      (resp),
        .resp_data_i (resp_data),
        .wb_o        (wb_o)
    );

endmodule

/* testbench/lq_clock_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps

module lq_clock_gen (
    output logic cpu_clock_o,
    output logic arst_n_o
);

    initial begin
        cpu_clock_o = 1'b0;
        forever #50 cpu_clock_o = ~cpu_clock_o;
    end

    // reset held for 8 cycles
    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge cpu_clock_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* testbench/lq_assertions.sv */
// load queue bound checks
`timescale 1ns/1ps

module lq_assertions
    import lq_pkg::*;
(
    input logic        cpu_clock_i,
    input logic        arst_n_i,
    input logic        flush_i,
    input logic        lsu_credit_o,
    input logic        mem_req_o,
    input logic [31:0] mem_addr_o,
    input logic        mem_ack_i,
    input lq_wb_t      wb_o
);

    int fail_count = 0;

    // request and address hold until the ack
    assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i || flush_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
        else begin
            fail_count++;
            $error("memory request dropped or address moved before ack");
        end

    // flush leaves the outputs quiet
    assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        flush_i |=> !wb_o.en && !mem_req_o && !lsu_credit_o)
        else begin
            fail_count++;
            $error("activity in the cycle after a flush");
        end

    assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        lsu_credit_o |-> !flush_i)
        else begin
            fail_count++;
            $error("credit returned during a flush");
        end

endmodule

bind load_queue_top lq_assertions u_lq_assertions (.*);

/* testbench/lq_tb.sv */
// load queue testbench
`timescale 1ns/1ps

module lq_tb
    import lq_pkg::*;
();

    localparam int LOADS_TOTAL = 122;
    localparam int ROB_N       = 2**ROB_W;

    logic             cpu_clock_i;
    logic             arst_n_i;
    logic             flush_i;
    logic             lsu_vld_i;
    lq_req_t          lsu_req_i;
    logic             lsu_credit_o;
    logic [TAG_W-1:0] cache_tag_o;
    logic             tag_hit_i;
    logic             tag_way_i;
    logic [IDX_W:0]   ram_addr_o;
    logic [31:0]      ram_data_i;
    logic [ROB_W-2:0] oldest_rob_i;
    logic             store_buf_empty_i;
    logic             mem_req_o;
    logic [31:0]      mem_addr_o;
    logic             mem_ack_i;
    logic [31:0]      mem_data_i;
    lq_wb_t           wb_o;

    integer           seed;
    integer           env_seed;
    int               errors;
    int               checks;
    int               credits;
    logic             credit_seen;
    logic             slow_mem;
    string            test_name;
    logic [31:0]      ram [2**(IDX_W+1)];
    logic             exp_pending [ROB_N];
    logic             exp_parked [ROB_N];
    logic             done [ROB_N];
    logic [REG_W-1:0] exp_dest [ROB_N];
    logic [31:0]      exp_data [ROB_N];
    logic [31:0]      exp_addr [ROB_N];
    logic [ROB_W-1:0] next_rob;
    logic [ROB_W-1:0] oldest;
    int               mem_wait;
    logic             mem_busy;
    logic [31:0]      mem_addr_hold;
    logic             req_d1;
    logic             sbe_d1;
    logic [ROB_W-2:0] oldest_d1;
    logic             found;

    lq_clock_gen u_clock_gen (
        .cpu_clock_o (cpu_clock_i),
        .arst_n_o    (arst_n_i)
    );

    load_queue_top DUT (.*);

    // tag array: low two tag bits both set is a miss
    function automatic logic tag_hits(input logic [TAG_W-1:0] tag);
        return tag[1:0] != 2'b11;
    endfunction

    function automatic logic [31:0] ram_fill(input int a);
        return (a * 32'h9E3779B1) ^ (a << 20) ^ 32'h3C5A96E1;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h01000193) ^ 32'h0F1EC3A5;
    endfunction

    function automatic logic [31:0] extend_lane(input logic [31:0] w, input lq_op_t op,
                                                input logic [1:0] off);
        logic [31:0] v;
        if (op.size == SZ_BYTE) begin
            v = (w >> (8 * off)) & 32'h000000ff;
            if (!op.zext && v[7]) begin
                v = v | 32'hffffff00;
            end
        end else if (op.size == SZ_HALF) begin
            v = (w >> (16 * off[1])) & 32'h0000ffff;
            if (!op.zext && v[15]) begin
                v = v | 32'hffff0000;
            end
        end else begin
            v = w;
        end
        return v;
    endfunction

    function automatic logic [31:0] apply_forward(input logic [31:0] w, input logic [31:0] d,
                                                  input logic [3:0] mask);
        logic [31:0] r;
        r = w;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                r[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        return r;
    endfunction

    // combinational tag lookup, one-cycle data RAM
    assign tag_hit_i = tag_hits(cache_tag_o);
    assign tag_way_i = cache_tag_o[5];

    always @(posedge cpu_clock_i) begin
        ram_data_i <= ram[ram_addr_o];
    end

    // memory and store buffer models
    always @(posedge cpu_clock_i) begin
        if (arst_n_i) begin
            mem_ack_i         <= 1'b0;
            store_buf_empty_i <= ($random(env_seed) & 3) != 0;
            if (mem_req_o && !req_d1 && !flush_i) begin
                found = 1'b0;
                for (int r = 0; r < ROB_N; r++) begin
                    if (exp_pending[r] && exp_parked[r] && r[ROB_W-2:0] == oldest_d1 &&
                        exp_addr[r] == mem_addr_o) begin
                        found = 1'b1;
                    end
                end
                assert (sbe_d1 && found) else begin
                    errors++;
                    $display("memory request issued while not oldest or stores pending");
                end
            end
            if (flush_i) begin
                mem_busy = 1'b0;
            end else if (mem_busy) begin
                assert (mem_addr_o == mem_addr_hold) else begin
                    errors++;
                    $display("memory address changed while the request was pending");
                end
                if (mem_wait == 0) begin
                    mem_ack_i  <= 1'b1;
                    mem_data_i <= mem_word(mem_addr_hold);
                    mem_busy = 1'b0;
                end else begin
                    mem_wait--;
                end
            end else if (mem_req_o && !mem_ack_i) begin
                mem_busy      = 1'b1;
                mem_addr_hold = mem_addr_o;
                mem_wait      = slow_mem ? 7 : ($random(env_seed) & 7);
            end
            req_d1    = mem_req_o;
            sbe_d1    = store_buf_empty_i;
            oldest_d1 = oldest_rob_i;
        end
    end

    // scoreboard and ROB
    always @(posedge cpu_clock_i) begin
        if (arst_n_i) begin
            if (wb_o.en) begin
                checks++;
                assert (exp_pending[wb_o.rob]) else begin
                    errors++;
                    $display("writeback for rob %0d with no load waiting for it", wb_o.rob);
                end
                if (exp_pending[wb_o.rob]) begin
                    assert (wb_o.dest == exp_dest[wb_o.rob]) else begin
                        errors++;
                        $display("[ERROR] %s rob %0d dest: expected %0d, actual %0d",
                                 test_name, wb_o.rob, exp_dest[wb_o.rob], wb_o.dest);
                    end
                    assert (wb_o.data == exp_data[wb_o.rob]) else begin
                        errors++;
                        $display("[ERROR] %s rob %0d data: expected %h, actual %h",
                                 test_name, wb_o.rob, exp_data[wb_o.rob], wb_o.data);
                    end
                    exp_pending[wb_o.rob] = 1'b0;
                    done[wb_o.rob]        = 1'b1;
                end
            end
            if (flush_i) begin
                for (int i = 0; i < ROB_N; i++) begin
                    exp_pending[i] = 1'b0;
                end
                oldest = next_rob;
            end
            while (oldest != next_rob && done[oldest]) begin
                oldest++;
            end
            oldest_rob_i <= oldest[ROB_W-2:0];
        end
    end

    task automatic step();
        @(posedge cpu_clock_i);
        lsu_vld_i <= 1'b0;
        credit_seen = lsu_credit_o;
        if (lsu_credit_o) begin
            credits++;
        end
        assert (credits <= LQ_CREDITS) else begin
            errors++;
            $display("more credits returned than loads sent");
        end
    endtask

    // mode 1 parks most loads in the miss queue
    task automatic issue_load(input int mode);
        lq_req_t     req;
        logic        park;
        logic [31:0] word;
        int          sel;
        req             = '0;
        req.ld.rob      = next_rob;
        sel             = $unsigned($random(seed)) % 3;
        req.ld.op.size  = sel[1:0];
        req.ld.op.zext  = $random(seed);
        req.ld.addr.raw = $random(seed);
        req.ld.addr.f.io = ($random(seed) & 7) < (mode == 1 ? 3 : 1);
        if (mode == 1 && ($random(seed) & 1)) begin
            req.ld.addr.f.tag[1:0] = 2'b11;
        end
        if (req.ld.op.size == SZ_HALF) begin
            req.ld.addr.f.offset[0] = 1'b0;
        end else if (req.ld.op.size == SZ_WORD) begin
            req.ld.addr.f.offset = 2'b00;
        end
        req.ld.dest        = (($random(seed) & 15) == 0) ? '0 : $random(seed);
        req.fwd.valid      = ($random(seed) & 3) == 0;
        req.fwd.resolvable = ($random(seed) & 3) != 0;
        req.fwd.data       = $random(seed);
        req.fwd.mask       = $random(seed);
        // x0 loads stay hits since they never report completion
        if (req.ld.dest == '0) begin
            req.ld.addr.f.io       = 1'b0;
            req.ld.addr.f.tag[1:0] = 2'b00;
            req.fwd.resolvable     = 1'b1;
        end
        park = req.ld.addr.f.io || !tag_hits(req.ld.addr.f.tag) ||
               (req.fwd.valid && !req.fwd.resolvable);
        if (park) begin
            word = mem_word(req.ld.addr.raw);
        end else begin
            word = ram[{req.ld.addr.f.tag[5], req.ld.addr.f.index}];
            if (req.fwd.valid) begin
                word = apply_forward(word, req.fwd.data, req.fwd.mask);
            end
        end
        exp_dest[next_rob]    = req.ld.dest;
        exp_data[next_rob]    = extend_lane(word, req.ld.op, req.ld.addr.f.offset);
        exp_addr[next_rob]    = req.ld.addr.raw;
        exp_parked[next_rob]  = park;
        exp_pending[next_rob] = (req.ld.dest != '0);
        done[next_rob]        = (req.ld.dest == '0);
        next_rob++;
        credits--;
        lsu_req_i <= req;
        lsu_vld_i <= 1'b1;
    endtask

    task automatic wait_drain();
        int busy;
        busy = 1;
        while (busy != 0) begin
            step();
            busy = (credits != LQ_CREDITS) ? 1 : 0;
            for (int i = 0; i < ROB_N; i++) begin
                if (exp_pending[i]) begin
                    busy++;
                end
            end
        end
        repeat (4) step();
    endtask

    task automatic run_test(input string name, input int n, input int mode);
        int sent;
        int start_errors;
        test_name    = name;
        start_errors = errors;
        sent         = 0;
        while (sent < n) begin
            step();
            if (credits > 0 && ($random(seed) & 3) != 0) begin
                issue_load(mode);
                sent++;
            end
        end
        wait_drain();
        $display("%s: %0d loads, %0d errors", name, n, errors - start_errors);
    endtask

    task automatic flush_test();
        int sent;
        int start_errors;
        test_name    = "flush";
        start_errors = errors;
        sent         = 0;
        while (sent < 12) begin
            step();
            if (credits > 0) begin
                issue_load(1);
                sent++;
            end
        end
        repeat (3) step();
        flush_i <= 1'b1;
        step();
        flush_i <= 1'b0;
        assert (!credit_seen) else begin
            errors++;
            $display("credit returned during flush");
        end
        credits = LQ_CREDITS;
        repeat (20) begin
            step();
            assert (!credit_seen) else begin
                errors++;
                $display("credit returned from an empty queue after flush");
            end
        end
        $display("flush: 12 loads, %0d errors", errors - start_errors);
    endtask

    initial begin
        seed              = 95;
        env_seed          = 95 * 7;
        errors            = 0;
        checks            = 0;
        credits           = LQ_CREDITS;
        slow_mem          = 1'b0;
        test_name         = "reset";
        next_rob          = '0;
        oldest            = '0;
        mem_busy          = 1'b0;
        req_d1            = 1'b0;
        sbe_d1            = 1'b0;
        oldest_d1         = '0;
        for (int i = 0; i < ROB_N; i++) begin
            exp_pending[i] = 1'b0;
            done[i]        = 1'b0;
        end
        for (int i = 0; i < 2**(IDX_W+1); i++) begin
            ram[i] = ram_fill(i);
        end
        flush_i           = 1'b0;
        lsu_vld_i         = 1'b0;
        lsu_req_i         = '0;
        ram_data_i        = '0;
        oldest_rob_i      = '0;
        store_buf_empty_i = 1'b0;
        mem_ack_i         = 1'b0;
        mem_data_i        = '0;
        wait (arst_n_i === 1'b1);
        run_test("random_mix", 60, 0);
        slow_mem = 1'b1;
        run_test("back_pressure", 30, 1);
        flush_test();
        slow_mem = 1'b0;
        run_test("after_flush", 20, 0);
        // bound assertion failures count as errors too
        errors = errors + DUT.u_lq_assertions.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the load count
    initial begin
        #(LOADS_TOTAL * 40 * 100);
        $display("watchdog expired before all loads completed");
        $display("Test failed");
        $finish;
    end

endmodule

/* flist.f */
design/lq_pkg.sv
design/lq_issue_buffer.sv
design/lq_lookup_stage.sv
design/lq_miss_queue.sv
design/lq_writeback_stage.sv
design/load_queue_top.sv
testbench/lq_clock_gen.sv
testbench/lq_assertions.sv
testbench/lq_tb.sv
